// File: logic/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Field widths
////////////////////////////////////////////////////////////////////////////
`define INSTR_W    32
`define REG_ADDR_W 5
`define CSR_ADDR_W 12

////////////////////////////////////////////////////////////////////////////
// CSR addresses the core implements
////////////////////////////////////////////////////////////////////////////
`define CSR_MISA      12'h301
`define CSR_MVENDORID 12'hF11 // Read-only ID block
`define CSR_MARCHID   12'hF12
`define CSR_MIMPID    12'hF13
`define CSR_MHARTID   12'hF14

`endif

// File: logic/rv_decode_pkg.sv
package rv_decode_pkg;

    ////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU,
        ALU_SEQ, ALU_SNE, ALU_SGE, ALU_SGEU // Branch compares
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC1_RS1, SRC1_PC, SRC1_ZERO, SRC1_IMM_CSR
    } alu_src1_e;

    typedef enum logic [1:0] {
        SRC2_RS2, SRC2_IMM, SRC2_FOUR
    } alu_src2_e;

    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_type_e;

    typedef enum logic [1:0] {
        MEM_BYTE, MEM_HALF, MEM_WORD // Same order as funct3[1:0]
    } mem_size_e;

    typedef enum logic [1:0] {
        PC_PLUS4, PC_BRANCH, PC_JAL, PC_JALR
    } pc_src_e;

    typedef enum logic [1:0] {
        CSR_READ, CSR_WRITE, CSR_SET, CSR_CLEAR
    } csr_op_e;

    ////////////////////////////////////////////////////////////////////////
    // Control bundle
    ////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        alu_op_e     alu_op;
        alu_src1_e   alu_src1;
        alu_src2_e   alu_src2;
        imm_type_e   imm_type;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic        mem_wen;
        mem_size_e   mem_size;
        logic        mem_sign_ext;
        logic        reg_alu_wen; // Writeback from ALU
        logic        reg_mem_wen; // Writeback from load data
        pc_src_e     pc_src;
        logic        is_branch;
        logic        csr_access;
        csr_op_e     csr_op;
        logic        illegal;
    } decode_ctrl_t;

    // One decoder's answer, register fields left at zero
    typedef struct packed {
        logic         hit;
        decode_ctrl_t ctrl;
    } decoder_result_t;

    // Bundle of a plain register-register ADD with nothing enabled
    localparam decode_ctrl_t CTRL_DEFAULT = '{
        alu_op:       ALU_ADD,
        alu_src1:     SRC1_RS1,
        alu_src2:     SRC2_RS2,
        imm_type:     IMM_I,
        rs1:          5'd0,
        rs2:          5'd0,
        rd:           5'd0,
        mem_wen:      1'b0,
        mem_size:     MEM_WORD,
        mem_sign_ext: 1'b0,
        reg_alu_wen:  1'b0,
        reg_mem_wen:  1'b0,
        pc_src:       PC_PLUS4,
        is_branch:    1'b0,
        csr_access:   1'b0,
        csr_op:       CSR_READ,
        illegal:      1'b0
    };

endpackage

// File: logic/alu_flow_decoder.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module alu_flow_decoder (
    input  logic [`INSTR_W-1:0]          instr_i,
    output rv_decode_pkg::decoder_result_t result_o
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;

    assign opcode = instr_i[6:0];
    assign funct7 = instr_i[31:25];
    assign funct3 = instr_i[14:12];

    always_comb begin
        result_o.hit  = 1'b1;
        result_o.ctrl = rv_decode_pkg::CTRL_DEFAULT;

        unique case (opcode)
            ////////////////////////////////////////////////////////////////
            // Arithmetic
            ////////////////////////////////////////////////////////////////
            rv_decode_pkg::OPC_OP: begin
                result_o.ctrl.reg_alu_wen = 1'b1;
                if (!(funct7 inside {7'h00, 7'h20}))
                    result_o.ctrl.illegal = 1'b1;
                if (!funct7[5]) begin
                    unique case (funct3)
                        3'b000: result_o.ctrl.alu_op = rv_decode_pkg::ALU_ADD;
                        3'b001: result_o.ctrl.alu_op = rv_decode_pkg::ALU_SLL;
                        3'b010: result_o.ctrl.alu_op = rv_decode_pkg::ALU_SLT;
                        3'b011: result_o.ctrl.alu_op = rv_decode_pkg::ALU_SLTU;
                        3'b100: result_o.ctrl.alu_op = rv_decode_pkg::ALU_XOR;
                        3'b101: result_o.ctrl.alu_op = rv_decode_pkg::ALU_SRL;
                        3'b110: result_o.ctrl.alu_op = rv_decode_pkg::ALU_OR;
                        3'b111: result_o.ctrl.alu_op = rv_decode_pkg::ALU_AND;
                    endcase
                end else begin
                    // Only sub and sra live under 0x20
                    unique case (funct3)
                        3'b000:  result_o.ctrl.alu_op = rv_decode_pkg::ALU_SUB;
                        3'b101:  result_o.ctrl.alu_op = rv_decode_pkg::ALU_SRA;
                        default: result_o.ctrl.illegal = 1'b1;
                    endcase
                end
            end

            rv_decode_pkg::OPC_OP_IMM: begin
                result_o.ctrl.alu_src2    = rv_decode_pkg::SRC2_IMM;
                result_o.ctrl.reg_alu_wen = 1'b1;
                unique case (funct3)
                    3'b000: result_o.ctrl.alu_op = rv_decode_pkg::ALU_ADD;
                    3'b010: result_o.ctrl.alu_op = rv_decode_pkg::ALU_SLT;
                    3'b011: result_o.ctrl.alu_op = rv_decode_pkg::ALU_SLTU;
                    3'b100: result_o.ctrl.alu_op = rv_decode_pkg::ALU_XOR;
                    3'b110: result_o.ctrl.alu_op = rv_decode_pkg::ALU_OR;
                    3'b111: result_o.ctrl.alu_op = rv_decode_pkg::ALU_AND;
                    3'b001: begin
                        result_o.ctrl.alu_op = rv_decode_pkg::ALU_SLL;
                        if (funct7 != 7'h00)
                            result_o.ctrl.illegal = 1'b1; // Shamt above 31
                    end
                    3'b101: begin
                        result_o.ctrl.alu_op = funct7[5] ? rv_decode_pkg::ALU_SRA
                                                         : rv_decode_pkg::ALU_SRL;
                        if (!(funct7 inside {7'h00, 7'h20}))
                            result_o.ctrl.illegal = 1'b1;
                    end
                endcase
            end

            rv_decode_pkg::OPC_LUI, rv_decode_pkg::OPC_AUIPC: begin
                // lui adds to zero, auipc adds to the PC
                result_o.ctrl.alu_src1    = opcode[5] ? rv_decode_pkg::SRC1_ZERO
                                                      : rv_decode_pkg::SRC1_PC;
                result_o.ctrl.alu_src2    = rv_decode_pkg::SRC2_IMM;
                result_o.ctrl.imm_type    = rv_decode_pkg::IMM_U;
                result_o.ctrl.reg_alu_wen = 1'b1;
            end

            ////////////////////////////////////////////////////////////////
            // Control flow
            ////////////////////////////////////////////////////////////////
            rv_decode_pkg::OPC_BRANCH: begin
                result_o.ctrl.imm_type  = rv_decode_pkg::IMM_B; // Target adder is elsewhere
                result_o.ctrl.pc_src    = rv_decode_pkg::PC_BRANCH;
                result_o.ctrl.is_branch = 1'b1;
                unique case (funct3)
                    3'b000:  result_o.ctrl.alu_op = rv_decode_pkg::ALU_SEQ;
                    3'b001:  result_o.ctrl.alu_op = rv_decode_pkg::ALU_SNE;
                    3'b100:  result_o.ctrl.alu_op = rv_decode_pkg::ALU_SLT;
                    3'b101:  result_o.ctrl.alu_op = rv_decode_pkg::ALU_SGE;
                    3'b110:  result_o.ctrl.alu_op = rv_decode_pkg::ALU_SLTU;
                    3'b111:  result_o.ctrl.alu_op = rv_decode_pkg::ALU_SGEU;
                    default: result_o.ctrl.illegal = 1'b1;
                endcase
            end

            rv_decode_pkg::OPC_JAL, rv_decode_pkg::OPC_JALR: begin
                // ALU produces the link address PC+4
                result_o.ctrl.alu_src1    = rv_decode_pkg::SRC1_PC;
                result_o.ctrl.alu_src2    = rv_decode_pkg::SRC2_FOUR;
                result_o.ctrl.reg_alu_wen = 1'b1;
                if (opcode[3]) begin // jal
                    result_o.ctrl.imm_type = rv_decode_pkg::IMM_J;
                    result_o.ctrl.pc_src   = rv_decode_pkg::PC_JAL;
                end else begin
                    result_o.ctrl.pc_src  = rv_decode_pkg::PC_JALR;
                    result_o.ctrl.illegal = (funct3 != 3'b000);
                end
            end

            default: result_o.hit = 1'b0;
        endcase
    end

endmodule

// File: logic/mem_csr_decoder.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module mem_csr_decoder (
    input  logic [`INSTR_W-1:0]          instr_i,
    output rv_decode_pkg::decoder_result_t result_o
);

    logic [6:0]               opcode;
    logic [2:0]               funct3;
    logic [`REG_ADDR_W-1:0]   rs1_field;
    logic [`REG_ADDR_W-1:0]   rd_field;
    logic [`CSR_ADDR_W-1:0]   csr_addr;
    logic                     csr_ro;    // Machine ID registers
    logic                     csr_known;
    rv_decode_pkg::csr_op_e   set_op;    // Set/clear collapse to read on rs1 == 0
    rv_decode_pkg::csr_op_e   clear_op;

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign rs1_field = instr_i[19:15];
    assign rd_field  = instr_i[11:7];
    assign csr_addr  = instr_i[31:20];

    assign csr_ro    = csr_addr inside {`CSR_MVENDORID, `CSR_MARCHID,
                                        `CSR_MIMPID, `CSR_MHARTID};
    assign csr_known = csr_ro || (csr_addr == `CSR_MISA);

    assign set_op   = (rs1_field == '0) ? rv_decode_pkg::CSR_READ : rv_decode_pkg::CSR_SET;
    assign clear_op = (rs1_field == '0) ? rv_decode_pkg::CSR_READ : rv_decode_pkg::CSR_CLEAR;

    always_comb begin
        result_o.hit  = 1'b1;
        result_o.ctrl = rv_decode_pkg::CTRL_DEFAULT;

        unique case (opcode)
            ////////////////////////////////////////////////////////////////
            // Loads and stores address memory at rs1 + imm
            ////////////////////////////////////////////////////////////////
            rv_decode_pkg::OPC_LOAD: begin
                result_o.ctrl.alu_src2     = rv_decode_pkg::SRC2_IMM;
                result_o.ctrl.reg_mem_wen  = 1'b1;
                result_o.ctrl.mem_sign_ext = !funct3[2]; // lbu/lhu zero extend
                unique case (funct3)
                    3'b000, 3'b100: result_o.ctrl.mem_size = rv_decode_pkg::MEM_BYTE;
                    3'b001, 3'b101: result_o.ctrl.mem_size = rv_decode_pkg::MEM_HALF;
                    3'b010:         result_o.ctrl.mem_size = rv_decode_pkg::MEM_WORD;
                    default:        result_o.ctrl.illegal  = 1'b1;
                endcase
            end

            rv_decode_pkg::OPC_STORE: begin
                result_o.ctrl.alu_src2 = rv_decode_pkg::SRC2_IMM;
                result_o.ctrl.imm_type = rv_decode_pkg::IMM_S;
                result_o.ctrl.mem_wen  = 1'b1;
                unique case (funct3)
                    3'b000:  result_o.ctrl.mem_size = rv_decode_pkg::MEM_BYTE;
                    3'b001:  result_o.ctrl.mem_size = rv_decode_pkg::MEM_HALF;
                    3'b010:  result_o.ctrl.mem_size = rv_decode_pkg::MEM_WORD;
                    default: result_o.ctrl.illegal  = 1'b1;
                endcase
            end

            ////////////////////////////////////////////////////////////////
            // System
            ////////////////////////////////////////////////////////////////
            rv_decode_pkg::OPC_SYSTEM: begin
                if ({rs1_field, rd_field} == '0) begin
                    // ecall, ebreak, mret and friends are not supported
                    result_o.ctrl.illegal = 1'b1;
                end else begin
                    result_o.ctrl.csr_access  = 1'b1;
                    result_o.ctrl.reg_alu_wen = 1'b1;
                    result_o.ctrl.alu_src2    = rv_decode_pkg::SRC2_IMM;
                    if (funct3[2])
                        result_o.ctrl.alu_src1 = rv_decode_pkg::SRC1_IMM_CSR; // zimm form

                    unique case (funct3[1:0])
                        2'b01:   result_o.ctrl.csr_op = rv_decode_pkg::CSR_WRITE;
                        2'b10:   result_o.ctrl.csr_op = set_op;
                        2'b11:   result_o.ctrl.csr_op = clear_op;
                        default: result_o.ctrl.illegal = 1'b1; // funct3 000 or 100
                    endcase

                    // Only reads reach the ID registers
                    if (!csr_known ||
                        (csr_ro && result_o.ctrl.csr_op != rv_decode_pkg::CSR_READ))
                        result_o.ctrl.illegal = 1'b1;
                end
            end

            default: result_o.hit = 1'b0;
        endcase
    end

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module decode_stage (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic [`INSTR_W-1:0]            instr_i,
    input  logic                           in_valid_i,
    input  logic                           out_ready_i,
    input  rv_decode_pkg::decoder_result_t alu_res_i,
    input  rv_decode_pkg::decoder_result_t mem_res_i,
    output logic                           in_ready_o,
    output rv_decode_pkg::decode_ctrl_t    ctrl_o,
    output logic                           out_valid_o
);

    rv_decode_pkg::decode_ctrl_t merged_ctrl;
    rv_decode_pkg::decode_ctrl_t ctrl_q;
    logic                        valid_q;

    ////////////////////////////////////////////////////////////////////////
    // Merge the result of the decoder that claims the opcode
    ////////////////////////////////////////////////////////////////////////
    always_comb begin
        if (alu_res_i.hit) begin
            merged_ctrl = alu_res_i.ctrl;
        end else if (mem_res_i.hit) begin
            merged_ctrl = mem_res_i.ctrl;
        end else begin
            merged_ctrl         = rv_decode_pkg::CTRL_DEFAULT;
            merged_ctrl.illegal = 1'b1; // Unknown opcode
        end
        merged_ctrl.rs1 = instr_i[15 +: `REG_ADDR_W];
        merged_ctrl.rs2 = instr_i[20 +: `REG_ADDR_W];
        merged_ctrl.rd  = instr_i[7  +: `REG_ADDR_W];
    end

    ////////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////////
    assign in_ready_o = !valid_q || out_ready_i; // Empty or draining this cycle

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            ctrl_q  <= '0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
            if (in_valid_i)
                ctrl_q <= merged_ctrl;
        end
    end

    assign ctrl_o      = ctrl_q;
    assign out_valid_o = valid_q;

endmodule

// File: logic/instr_decoder_top.sv
`timescale 1ns/1ps
`include "decode_config.svh"

module instr_decoder_top (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic [`INSTR_W-1:0]         instr_i,
    input  logic                        in_valid_i,
    input  logic                        out_ready_i,
    output logic                        in_ready_o,
    output rv_decode_pkg::decode_ctrl_t ctrl_o,
    output logic                        out_valid_o
);

    rv_decode_pkg::decoder_result_t alu_res;
    rv_decode_pkg::decoder_result_t mem_res;

    // ALU, upper-immediate and control-flow opcodes
    alu_flow_decoder u_alu_flow_decoder (
        .instr_i  (instr_i),
        .result_o (alu_res)
    );

    // Memory and system opcodes
    mem_csr_decoder u_mem_csr_decoder (
        .instr_i  (instr_i),
        .result_o (mem_res)
    );

    decode_stage u_decode_stage (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .instr_i     (instr_i),
        .in_valid_i  (in_valid_i),
        .out_ready_i (out_ready_i),
        .alu_res_i   (alu_res),
        .mem_res_i   (mem_res),
        .in_ready_o  (in_ready_o),
        .ctrl_o      (ctrl_o),
        .out_valid_o (out_valid_o)
    );

endmodule

// File: dv/instr_decoder_tb.sv
`timescale 1ns/1ps

module instr_decoder_tb;

    localparam int NUM_VEC   = 37;
    localparam int CTRL_W    = $bits(rv_decode_pkg::decode_ctrl_t);
    localparam int MAX_CYCLE = 20 * NUM_VEC + 100;

    logic                        clk_i;
    logic                        rst_n_i;
    logic [31:0]                 instr_i;
    logic                        in_valid_i;
    logic                        out_ready_i;
    logic                        in_ready_o;
    rv_decode_pkg::decode_ctrl_t ctrl_o;
    logic                        out_valid_o;

    logic [63:0]                 vec_mem [0:2*NUM_VEC-1]; // Instr and bundle alternate
    rv_decode_pkg::decode_ctrl_t exp_q [$];
    int                          mismatch_cnt;
    int                          other_cnt;
    int                          cycle_cnt;
    int                          seed;

    instr_decoder_top dut0 (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .instr_i     (instr_i),
        .in_valid_i  (in_valid_i),
        .out_ready_i (out_ready_i),
        .in_ready_o  (in_ready_o),
        .ctrl_o      (ctrl_o),
        .out_valid_o (out_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Run limit
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLE) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        other_cnt++;
        $display("Timeout: not every expected bundle left the DUT within %0d cycles",
                 MAX_CYCLE);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        $display("sim failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and checks
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int                          sent;
        int                          recv;
        logic                        stalled;
        logic                        took;
        rv_decode_pkg::decode_ctrl_t held;
        rv_decode_pkg::decode_ctrl_t exp;

        sent         = 0;
        recv         = 0;
        stalled      = 1'b0;
        took         = 1'b0;
        held         = '0;
        mismatch_cnt = 0;
        other_cnt    = 0;
        seed         = 51;
        rst_n_i      = 1'b0;
        instr_i      = '0;
        in_valid_i   = 1'b0;
        out_ready_i  = 1'b0;

        for (int i = 0; i < 2 * NUM_VEC; i++)
            vec_mem[i] = {32'hFFFF_FFFF, 32'(i)}; // Marks entries the file never wrote
        $readmemh("dv/decode_golden.txt", vec_mem);
        assert (vec_mem[2*NUM_VEC-1][63:32] != 32'hFFFF_FFFF) else begin
            other_cnt++;
            $display("The golden file holds fewer than %0d vectors", NUM_VEC);
        end

        repeat (16) @(posedge clk_i);
        #1 rst_n_i = 1'b1;

        @(negedge clk_i);
        assert (out_valid_o == 1'b0 && ctrl_o == '0) else begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: output register not empty after reset", $time);
        end

        while (recv < NUM_VEC) begin
            // Output side is stable between edges
            if (took) begin
                assert (out_valid_o) else begin
                    mismatch_cnt++;
                    $display("MISMATCH at %0t: accepted instruction not on the output",
                             $time);
                end
            end
            if (stalled) begin
                assert (out_valid_o && ctrl_o == held) else begin
                    mismatch_cnt++;
                    $display("MISMATCH at %0t: output changed while stalled, %h -> %h",
                             $time, held, ctrl_o);
                end
            end
            assert (in_ready_o == (!out_valid_o || out_ready_i)) else begin
                mismatch_cnt++;
                $display("MISMATCH at %0t: in_ready_o %b with out_valid_o %b out_ready_i %b",
                         $time, in_ready_o, out_valid_o, out_ready_i);
            end
            if (out_valid_o && out_ready_i) begin
                assert (exp_q.size() > 0) else begin
                    other_cnt++;
                    $display("Output transfer at %0t with no instruction pending", $time);
                end
                if (exp_q.size() > 0) begin
                    exp = exp_q.pop_front();
                    assert (ctrl_o == exp) else begin
                        mismatch_cnt++;
                        $display("MISMATCH at %0t: vector %0d expected %h got %h",
                                 $time, recv, exp, ctrl_o);
                    end
                end
                recv++;
            end
            stalled = out_valid_o && !out_ready_i;
            held    = ctrl_o;

            // Input side
            took = in_valid_i && in_ready_o;
            if (took) begin
                exp_q.push_back(rv_decode_pkg::decode_ctrl_t'(vec_mem[2*sent+1][CTRL_W-1:0]));
                sent++;
            end

            @(posedge clk_i);
            #1;
            in_valid_i  = (sent < NUM_VEC) && (($random(seed) & 3) != 0);
            instr_i     = (sent < NUM_VEC) ? vec_mem[2*sent][31:0] : 32'h0;
            out_ready_i = ($random(seed) & 3) != 0; // Ready three cycles in four
            @(negedge clk_i);
        end

        assert (exp_q.size() == 0) else begin
            other_cnt++;
            $display("%0d expected bundles never came out", exp_q.size());
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: dv/decode_golden.txt
// Each line: instruction word, then the expected decode_ctrl_t (39 bits) in hex
// Bundle fields MSB first: alu_op src1 src2 imm rs1 rs2 rd mem/wb/pc/csr flags illegal
003100B3 00010C2900
403100B3 08010C2900
403150B3 38010C2900
003130B3 48010C2900
023100B3 00010C2901
403110B3 00010C2901
FFF10093 00817C2900
00311093 28810C2900
40315093 38810C2900
02311093 28810C2901
7FF17093 20817C2900
123450B7 04B40C2900
12345097 02B40C2900
00310063 50210C0830
00317063 68210C0830
00314063 40210C0830
00312063 00210C0831
000000EF 0340002940
000100E7 0301002960
000110E7 0301002961
00012083 0081002A80
00014083 0081002080
00011083 0081002680
00013083 0081002A81
00310023 00910C1000
00312023 00910C1800
00313023 00910C1801
301020F3 0080042908
301110F3 008104290A
F14130F3 008150290F
F11110F3 008144290B
F11020F3 0080442908
301070F3 0680042908
3012E0F3 068284290C
7C0110F3 008100290B
00000073 0000000801
003100FF 00010C2801

// File: list.f
+incdir+logic
logic/rv_decode_pkg.sv
logic/alu_flow_decoder.sv
logic/mem_csr_decoder.sv
logic/decode_stage.sv
logic/instr_decoder_top.sv
dv/instr_decoder_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wall
TOP       ?= instr_decoder_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
